// File: source/rob_cfg_pkg.sv
// Sizing constants of the reorder buffer; the top level takes its parameter defaults from here
package rob_cfg_pkg;

   // log2 of the bank count
   // Issue width and commit width both equal the bank count
   localparam int p_banks_def = 1;

   // log2 of the entries held by one bank
   localparam int p_depth_def = 3;

   // Writeback lanes into the buffer
   localparam int wb_lanes = 2;

   // Program counter width
   localparam int pc_w = 32;

   // Result word width
   localparam int xlen = 32;

   // Architectural destination register index
   localparam int reg_aw = 5;

endpackage

// File: source/rob_types_pkg.sv
// Payload types carried by the reorder buffer; imported by the banks and the top level
package rob_types_pkg;

   // Written at push time, read back at commit
   typedef struct packed {
      logic [rob_cfg_pkg::pc_w-1:0]   pc;
      logic [rob_cfg_pkg::reg_aw-1:0] rd;
   } issue_payload_t;

   // Written by a writeback lane, read back at commit
   typedef struct packed {
      logic [rob_cfg_pkg::xlen-1:0] result;
      logic                         exc;
   } wb_result_t;

endpackage

// File: source/rob_entry_store.sv
// Register array with one write port and an asynchronous read, used for each bank payload type
`timescale 1ns/1ps

module rob_entry_store #(
   parameter type entry_t = rob_types_pkg::issue_payload_t,
   parameter int  P_DEPTH = rob_cfg_pkg::p_depth_def
) (
   input  logic               clk,
   input  logic               we,
   input  logic [P_DEPTH-1:0] waddr,
   input  entry_t             wdata,
   input  logic [P_DEPTH-1:0] raddr,
   output entry_t             rdata
);
   localparam int DEPTH = 2**P_DEPTH;

   entry_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Head of the bank is visible in the same cycle
   assign rdata = mem[raddr];

endmodule

// File: source/rob_bank.sv
// One reorder buffer bank, a circular queue of entries with done flags and two payload stores
`timescale 1ns/1ps

module rob_bank #(
   parameter int P_DEPTH = rob_cfg_pkg::p_depth_def
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          flush,
   input  logic                          push,
   input  rob_types_pkg::issue_payload_t push_data,
   input  logic                          pop,
   input  logic                          wb_en,
   input  logic [P_DEPTH-1:0]            wb_slot,
   input  rob_types_pkg::wb_result_t     wb_data,
   output logic                          not_full,
   output logic [P_DEPTH-1:0]            wr_slot,
   output rob_types_pkg::issue_payload_t head_payload,
   output rob_types_pkg::wb_result_t     head_result,
   output logic                          head_done
);
   import rob_types_pkg::*;

   localparam int DEPTH = 2**P_DEPTH;

   logic [P_DEPTH-1:0] rd_ptr;
   logic [P_DEPTH-1:0] wr_ptr;
   logic [P_DEPTH:0]   count;
   logic [DEPTH-1:0]   done;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (!push && pop)
            count <= count - 1'b1;
      end
   end

   // New entry starts pending, its writeback marks it done
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         done <= '0;
      else
      begin
         if (push && !flush)
            done[wr_ptr] <= 1'b0;
         if (wb_en)
            done[wb_slot] <= 1'b1;
      end
   end

   assign not_full  = count != (P_DEPTH+1)'(DEPTH);
   assign wr_slot   = wr_ptr;
   assign head_done = done[rd_ptr] && (count != '0);

   rob_entry_store #(
      .entry_t (issue_payload_t),
      .P_DEPTH (P_DEPTH)
   ) i_payload_store (
      .clk   (clk),
      .we    (push),
      .waddr (wr_ptr),
      .wdata (push_data),
      .raddr (rd_ptr),
      .rdata (head_payload)
   );

   rob_entry_store #(
      .entry_t (wb_result_t),
      .P_DEPTH (P_DEPTH)
   ) i_result_store (
      .clk   (clk),
      .we    (wb_en),
      .waddr (wb_slot),
      .wdata (wb_data),
      .raddr (rd_ptr),
      .rdata (head_result)
   );

endmodule

// File: source/rob_ring_ptr.sv
// Head and tail bank pointers of the reorder buffer, expanded into per-bank push and pop enables
`timescale 1ns/1ps

module rob_ring_ptr #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               flush,
   input  logic [P_BANKS:0]   push_size,
   input  logic [P_BANKS:0]   pop_size,
   output logic [P_BANKS-1:0] head,
   output logic [P_BANKS-1:0] tail,
   output logic               bank_push [2**P_BANKS],
   output logic               bank_pop [2**P_BANKS]
);
   localparam int BANKS = 2**P_BANKS;

   logic [P_BANKS-1:0] tail_dist [BANKS];
   logic [P_BANKS-1:0] head_dist [BANKS];

   // Distance wraps modulo the bank count
   for (genvar b = 0; b < BANKS; b++)
   begin : g_enable
      assign tail_dist[b] = P_BANKS'(b) - tail;
      assign head_dist[b] = P_BANKS'(b) - head;
      assign bank_push[b] = {1'b0, tail_dist[b]} < push_size;
      assign bank_pop[b]  = {1'b0, head_dist[b]} < pop_size;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head <= '0;
         tail <= '0;
      end
      else if (flush)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         // A full group of BANKS leaves the pointer in place
         head <= head + pop_size[P_BANKS-1:0];
         tail <= tail + push_size[P_BANKS-1:0];
      end
   end

endmodule

// File: source/rob_wb_route.sv
// Writeback bank conflict check and steering of accepted writebacks onto the bank write ports
`timescale 1ns/1ps

module rob_wb_route #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def,
   parameter int P_DEPTH = rob_cfg_pkg::p_depth_def
) (
   input  logic                      wb_valid [rob_cfg_pkg::wb_lanes],
   input  logic [P_BANKS-1:0]        wb_bank [rob_cfg_pkg::wb_lanes],
   input  logic [P_DEPTH-1:0]        wb_slot [rob_cfg_pkg::wb_lanes],
   input  rob_types_pkg::wb_result_t wb_result [rob_cfg_pkg::wb_lanes],
   output logic                      wb_ready [rob_cfg_pkg::wb_lanes],
   output logic                      bank_wb_en [2**P_BANKS],
   output logic [P_DEPTH-1:0]        bank_wb_slot [2**P_BANKS],
   output rob_types_pkg::wb_result_t bank_wb_data [2**P_BANKS]
);
   import rob_cfg_pkg::*;

   localparam int BANKS = 2**P_BANKS;

   logic wb_take [wb_lanes];

   // Lane 0 never waits, a higher lane yields to any valid lower lane on its bank
   always_comb
   begin
      for (int l = 0; l < wb_lanes; l++)
      begin
         wb_ready[l] = 1'b1;
         for (int k = 0; k < l; k++)
         begin
            if (wb_valid[k] && (wb_bank[k] == wb_bank[l]))
               wb_ready[l] = 1'b0;
         end
         wb_take[l] = wb_valid[l] && wb_ready[l];
      end
   end

   // At most one accepted lane hits a bank, so OR merging is safe
   always_comb
   begin
      for (int b = 0; b < BANKS; b++)
      begin
         bank_wb_en[b]   = 1'b0;
         bank_wb_slot[b] = '0;
         bank_wb_data[b] = '0;
         for (int l = 0; l < wb_lanes; l++)
         begin
            if (wb_take[l] && (wb_bank[l] == P_BANKS'(b)))
            begin
               bank_wb_en[b]   = 1'b1;
               bank_wb_slot[b] = bank_wb_slot[b] | wb_slot[l];
               bank_wb_data[b] = bank_wb_data[b] | wb_result[l];
            end
         end
      end
   end

endmodule

// File: source/rob_commit_sel.sv
// Commit lane selection, rotates the bank heads into program order and builds the valid prefix
`timescale 1ns/1ps

module rob_commit_sel #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def
) (
   input  logic [P_BANKS-1:0]            head,
   input  rob_types_pkg::issue_payload_t bank_payload [2**P_BANKS],
   input  rob_types_pkg::wb_result_t     bank_result [2**P_BANKS],
   input  logic                          bank_done [2**P_BANKS],
   output logic                          cmt_valid [2**P_BANKS],
   output rob_types_pkg::issue_payload_t cmt_payload [2**P_BANKS],
   output rob_types_pkg::wb_result_t     cmt_result [2**P_BANKS]
);
   localparam int LANES = 2**P_BANKS;

   logic [P_BANKS-1:0] lane_bank [LANES];

   // Lane 0 always holds the oldest entry
   for (genvar i = 0; i < LANES; i++)
   begin : g_lane
      assign lane_bank[i]   = head + P_BANKS'(i);
      assign cmt_payload[i] = bank_payload[lane_bank[i]];
      assign cmt_result[i]  = bank_result[lane_bank[i]];
   end

   // A lane commits only behind a run of done lanes
   always_comb
   begin
      cmt_valid[0] = bank_done[lane_bank[0]];
      for (int i = 1; i < LANES; i++)
      begin
         cmt_valid[i] = cmt_valid[i-1] && bank_done[lane_bank[i]];
      end
   end

endmodule

// File: source/rob_top.sv
// Banked reorder buffer top level, the DUT seen by the issue, writeback and commit stages
`timescale 1ns/1ps

module rob_top #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def,
   parameter int P_DEPTH = rob_cfg_pkg::p_depth_def
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          flush,
   // Issue side
   input  logic [P_BANKS:0]              push_size,
   input  rob_types_pkg::issue_payload_t push_payload [2**P_BANKS],
   output logic                          push_ready,
   output logic [P_BANKS-1:0]            free_bank [2**P_BANKS],
   output logic [P_DEPTH-1:0]            free_slot [2**P_BANKS],
   // Writeback side
   input  logic                          wb_valid [rob_cfg_pkg::wb_lanes],
   input  logic [P_BANKS-1:0]            wb_bank [rob_cfg_pkg::wb_lanes],
   input  logic [P_DEPTH-1:0]            wb_slot [rob_cfg_pkg::wb_lanes],
   input  rob_types_pkg::wb_result_t     wb_result [rob_cfg_pkg::wb_lanes],
   output logic                          wb_ready [rob_cfg_pkg::wb_lanes],
   // Commit side
   output logic                          cmt_valid [2**P_BANKS],
   output rob_types_pkg::issue_payload_t cmt_payload [2**P_BANKS],
   output rob_types_pkg::wb_result_t     cmt_result [2**P_BANKS],
   input  logic [P_BANKS:0]              cmt_pop_size
);
   import rob_types_pkg::*;

   localparam int BANKS = 2**P_BANKS;

   logic [P_BANKS-1:0] head;
   logic [P_BANKS-1:0] tail;
   logic               bank_push [BANKS];
   logic               bank_pop [BANKS];
   logic               bank_wb_en [BANKS];
   logic [P_DEPTH-1:0] bank_wb_slot [BANKS];
   wb_result_t         bank_wb_data [BANKS];
   logic               bank_not_full [BANKS];
   logic [P_DEPTH-1:0] bank_wr_slot [BANKS];
   issue_payload_t     bank_payload [BANKS];
   wb_result_t         bank_result [BANKS];
   logic               bank_done [BANKS];
   logic [P_BANKS-1:0] push_lane [BANKS];

   rob_ring_ptr #(
      .P_BANKS (P_BANKS)
   ) i_ring_ptr (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .push_size (push_size),
      .pop_size  (cmt_pop_size),
      .head      (head),
      .tail      (tail),
      .bank_push (bank_push),
      .bank_pop  (bank_pop)
   );

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      // Issue lane whose entry lands in this bank
      assign push_lane[b] = P_BANKS'(b) - tail;

      rob_bank #(
         .P_DEPTH (P_DEPTH)
      ) i_bank (
         .clk          (clk),
         .rst_n        (rst_n),
         .flush        (flush),
         .push         (bank_push[b]),
         .push_data    (push_payload[push_lane[b]]),
         .pop          (bank_pop[b]),
         .wb_en        (bank_wb_en[b]),
         .wb_slot      (bank_wb_slot[b]),
         .wb_data      (bank_wb_data[b]),
         .not_full     (bank_not_full[b]),
         .wr_slot      (bank_wr_slot[b]),
         .head_payload (bank_payload[b]),
         .head_result  (bank_result[b]),
         .head_done    (bank_done[b])
      );
   end

   rob_wb_route #(
      .P_BANKS (P_BANKS),
      .P_DEPTH (P_DEPTH)
   ) i_wb_route (
      .wb_valid     (wb_valid),
      .wb_bank      (wb_bank),
      .wb_slot      (wb_slot),
      .wb_result    (wb_result),
      .wb_ready     (wb_ready),
      .bank_wb_en   (bank_wb_en),
      .bank_wb_slot (bank_wb_slot),
      .bank_wb_data (bank_wb_data)
   );

   rob_commit_sel #(
      .P_BANKS (P_BANKS)
   ) i_commit_sel (
      .head         (head),
      .bank_payload (bank_payload),
      .bank_result  (bank_result),
      .bank_done    (bank_done),
      .cmt_valid    (cmt_valid),
      .cmt_payload  (cmt_payload),
      .cmt_result   (cmt_result)
   );

   // Slots offered to issue, lane i goes to the bank i steps past the tail
   for (genvar l = 0; l < BANKS; l++)
   begin : g_free
      assign free_bank[l] = tail + P_BANKS'(l);
      assign free_slot[l] = bank_wr_slot[free_bank[l]];
   end

   // One full bank stalls the whole issue group
   always_comb
   begin
      push_ready = 1'b1;
      for (int b = 0; b < BANKS; b++)
      begin
         push_ready = push_ready & bank_not_full[b];
      end
   end

endmodule

// File: dv/rob_props.sv
// Concurrent assertions on the reorder buffer ports, bound into every rob_top instance
`timescale 1ns/1ps

module rob_props #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def
) (
   input logic               clk,
   input logic               rst_n,
   input logic               flush,
   input logic [P_BANKS:0]   push_size,
   input logic               push_ready,
   input logic               wb_valid [rob_cfg_pkg::wb_lanes],
   input logic [P_BANKS-1:0] wb_bank [rob_cfg_pkg::wb_lanes],
   input logic               wb_ready [rob_cfg_pkg::wb_lanes],
   input logic               cmt_valid [2**P_BANKS]
);
   int fail_count;

   initial
      fail_count = 0;

   // Lane 0 never waits
   a_lane0_ready: assert property (@(posedge clk) disable iff (!rst_n) wb_ready[0])
   else
   begin
      $error("writeback lane 0 not ready");
      fail_count++;
   end

   // Lane 1 held off only by a valid lane 0 on the same bank
   a_lane1_conflict: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ready[1] == !(wb_valid[0] && (wb_bank[0] == wb_bank[1])))
   else
   begin
      $error("writeback lane 1 ready does not follow the bank conflict rule");
      fail_count++;
   end

   a_commit_prefix: assert property (@(posedge clk) disable iff (!rst_n)
      cmt_valid[1] |-> cmt_valid[0])
   else
   begin
      $error("commit lane 1 valid without lane 0");
      fail_count++;
   end

   a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
      flush |=> !cmt_valid[0])
   else
   begin
      $error("commit lane valid in the cycle after a flush");
      fail_count++;
   end

   a_push_legal: assert property (@(posedge clk) disable iff (!rst_n)
      (push_size != '0) |-> push_ready)
   else
   begin
      $error("push presented while push_ready is low");
      fail_count++;
   end

endmodule

bind rob_top rob_props #(
   .P_BANKS (P_BANKS)
) i_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .flush      (flush),
   .push_size  (push_size),
   .push_ready (push_ready),
   .wb_valid   (wb_valid),
   .wb_bank    (wb_bank),
   .wb_ready   (wb_ready),
   .cmt_valid  (cmt_valid)
);

// File: dv/rob_checker.sv
// Reference model of the reorder buffer, compares every DUT response and reports per test
`timescale 1ns/1ps

module rob_checker #(
   parameter int P_BANKS = rob_cfg_pkg::p_banks_def,
   parameter int P_DEPTH = rob_cfg_pkg::p_depth_def
) (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          flush,
   input logic [P_BANKS:0]              push_size,
   input rob_types_pkg::issue_payload_t push_payload [2**P_BANKS],
   input logic                          push_ready,
   input logic [P_BANKS-1:0]            free_bank [2**P_BANKS],
   input logic [P_DEPTH-1:0]            free_slot [2**P_BANKS],
   input logic                          wb_valid [rob_cfg_pkg::wb_lanes],
   input logic [P_BANKS-1:0]            wb_bank [rob_cfg_pkg::wb_lanes],
   input logic [P_DEPTH-1:0]            wb_slot [rob_cfg_pkg::wb_lanes],
   input rob_types_pkg::wb_result_t     wb_result [rob_cfg_pkg::wb_lanes],
   input logic                          wb_ready [rob_cfg_pkg::wb_lanes],
   input logic                          cmt_valid [2**P_BANKS],
   input rob_types_pkg::issue_payload_t cmt_payload [2**P_BANKS],
   input rob_types_pkg::wb_result_t     cmt_result [2**P_BANKS],
   input logic [P_BANKS:0]              cmt_pop_size
);
   import rob_cfg_pkg::*;
   import rob_types_pkg::*;

   localparam int BANKS = 2**P_BANKS;
   localparam int DEPTH = 2**P_DEPTH;

   // Program order queue, oldest entry first
   logic [P_BANKS-1:0] q_bank [$];
   logic [P_DEPTH-1:0] q_slot [$];
   issue_payload_t     q_pay [$];
   logic               q_done [$];
   wb_result_t         q_res [$];

   logic [P_BANKS-1:0] m_tail;
   logic [P_DEPTH-1:0] m_wr [BANKS];

   int errors = 0;
   int checks = 0;
   int tests = 0;
   int test_errors = 0;
   int test_checks = 0;

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      checks++;
      test_checks++;
      if (got !== exp)
      begin
         $display("ERROR %s: got %0h expected %0h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_problem(input string what);
      $display("%s", what);
      errors++;
      test_errors++;
   endtask

   task automatic report_test(input string name);
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      tests++;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic report_total();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
   endtask

   task automatic clear_model();
      q_bank.delete();
      q_slot.delete();
      q_pay.delete();
      q_done.delete();
      q_res.delete();
      m_tail = '0;
      for (int b = 0; b < BANKS; b++)
         m_wr[b] = '0;
   endtask

   // Inputs and state are steady at the falling edge
   always @(negedge clk)
   begin : p_model
      logic               exp_bit;
      logic [P_BANKS-1:0] exp_bank;
      int                 count [BANKS];
      int                 hit;
      if (rst_n !== 1'b1)
         clear_model();
      else
      begin
         for (int b = 0; b < BANKS; b++)
            count[b] = 0;
         foreach (q_bank[j])
            count[q_bank[j]]++;
         exp_bit = 1'b1;
         for (int b = 0; b < BANKS; b++)
            if (count[b] >= DEPTH)
               exp_bit = 1'b0;
         compare_value("push_ready", 64'(push_ready), 64'(exp_bit));

         // Lane i valid only behind i older done entries
         exp_bit = 1'b1;
         for (int i = 0; i < BANKS; i++)
         begin
            if (i >= q_done.size() || !q_done[i])
               exp_bit = 1'b0;
            compare_value($sformatf("cmt_valid[%0d]", i), 64'(cmt_valid[i]), 64'(exp_bit));
         end

         // Lane 1 waits on a valid lane 0 aimed at its own bank
         compare_value("wb_ready[0]", 64'(wb_ready[0]), 64'(1'b1));
         exp_bit = !(wb_valid[0] && (wb_bank[0] == wb_bank[1]));
         compare_value("wb_ready[1]", 64'(wb_ready[1]), 64'(exp_bit));

         for (int i = 0; i < BANKS; i++)
         begin
            if (i < int'(cmt_pop_size))
            begin
               if (i >= q_pay.size())
                  report_problem($sformatf("commit popped lane %0d with no entry left", i));
               else
               begin
                  compare_value($sformatf("cmt_payload[%0d]", i), 64'(cmt_payload[i]),
                                64'(q_pay[i]));
                  compare_value($sformatf("cmt_result[%0d]", i), 64'(cmt_result[i]),
                                64'(q_res[i]));
               end
            end
         end

         if (flush)
            clear_model();
         else
         begin
            for (int l = 0; l < wb_lanes; l++)
            begin
               if (wb_valid[l] && wb_ready[l])
               begin
                  hit = -1;
                  foreach (q_bank[j])
                     if (hit < 0 && q_bank[j] == wb_bank[l] && q_slot[j] == wb_slot[l])
                        hit = j;
                  if (hit < 0)
                     report_problem($sformatf("writeback lane %0d hit no entry in flight", l));
                  else
                  begin
                     q_done[hit] = 1'b1;
                     q_res[hit]  = wb_result[l];
                  end
               end
            end

            for (int i = 0; i < BANKS; i++)
            begin
               if (i < int'(cmt_pop_size) && q_pay.size() > 0)
               begin
                  void'(q_bank.pop_front());
                  void'(q_slot.pop_front());
                  void'(q_pay.pop_front());
                  void'(q_done.pop_front());
                  void'(q_res.pop_front());
               end
            end

            if (push_size != '0 && !push_ready)
               report_problem("push presented while push_ready was low");
            // Round robin from the tail, each bank fills its own slots in order
            for (int i = 0; i < BANKS; i++)
            begin
               if (i < int'(push_size))
               begin
                  exp_bank = m_tail + P_BANKS'(i);
                  compare_value($sformatf("free_bank[%0d]", i), 64'(free_bank[i]),
                                64'(exp_bank));
                  compare_value($sformatf("free_slot[%0d]", i), 64'(free_slot[i]),
                                64'(m_wr[exp_bank]));
                  q_bank.push_back(exp_bank);
                  q_slot.push_back(m_wr[exp_bank]);
                  q_pay.push_back(push_payload[i]);
                  q_done.push_back(1'b0);
                  q_res.push_back('0);
                  m_wr[exp_bank] = m_wr[exp_bank] + 1'b1;
               end
            end
            m_tail = m_tail + push_size[P_BANKS-1:0];
         end
      end
   end

endmodule

// File: dv/tb_rob_top.sv
// Testbench top for the reorder buffer, runs random push, writeback and commit traffic
`timescale 1ns/1ps

module tb_rob_top;
   import rob_cfg_pkg::*;
   import rob_types_pkg::*;

   localparam int BANKS = 2**p_banks_def;
   localparam int KW = p_banks_def + p_depth_def;
   localparam int RANDOM_LEN = 400;
   localparam int FULL_LEN = 60;
   localparam int FLUSH_LEN = 80;
   localparam int DRAIN_MAX = 200;
   localparam int CYCLE_LIMIT = RANDOM_LEN + FULL_LEN + 2 * FLUSH_LEN + 3 * DRAIN_MAX + 50;

   logic                   clk;
   logic                   rst_n;
   logic                   flush;
   logic [p_banks_def:0]   push_size;
   issue_payload_t         push_payload [BANKS];
   logic                   push_ready;
   logic [p_banks_def-1:0] free_bank [BANKS];
   logic [p_depth_def-1:0] free_slot [BANKS];
   logic                   wb_valid [wb_lanes];
   logic [p_banks_def-1:0] wb_bank [wb_lanes];
   logic [p_depth_def-1:0] wb_slot [wb_lanes];
   wb_result_t             wb_result [wb_lanes];
   logic                   wb_ready [wb_lanes];
   logic                   cmt_valid [BANKS];
   issue_payload_t         cmt_payload [BANKS];
   wb_result_t             cmt_result [BANKS];
   logic [p_banks_def:0]   cmt_pop_size;

   logic [31:0]   lfsr;
   // Bank and slot of entries still waiting for a writeback
   logic [KW-1:0] pending [$];
   int            in_flight;
   int            cycles = 0;

   rob_top #(
      .P_BANKS (p_banks_def),
      .P_DEPTH (p_depth_def)
   ) i_dut (.*);

   rob_checker #(
      .P_BANKS (p_banks_def),
      .P_DEPTH (p_depth_def)
   ) i_checker (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic void drop_pending(input logic [KW-1:0] key);
      int hit;
      hit = -1;
      foreach (pending[j])
         if (hit < 0 && pending[j] == key)
            hit = j;
      if (hit >= 0)
         pending.delete(hit);
   endfunction

   // What the coming edge accepts, seen while inputs are steady
   task automatic note_accepted();
      for (int l = 0; l < wb_lanes; l++)
         if (wb_valid[l] && wb_ready[l])
            drop_pending({wb_bank[l], wb_slot[l]});
      for (int i = 0; i < BANKS; i++)
         if (i < int'(push_size))
            pending.push_back({free_bank[i], free_slot[i]});
      in_flight = in_flight + int'(push_size) - int'(cmt_pop_size);
      if (flush)
      begin
         pending.delete();
         in_flight = 0;
      end
   endtask

   task automatic step(input bit push_en, input bit wb_en, input bit pop_en);
      logic [KW-1:0]        key0;
      logic [KW-1:0]        key1;
      logic                 v0;
      logic                 v1;
      logic                 hold1;
      logic [p_banks_def:0] n_push;
      logic [p_banks_def:0] n_pop;
      logic [31:0]          r;
      int                   idx;
      int                   lanes_valid;
      issue_payload_t       pay;
      wb_result_t           res;
      key0 = '0;
      v0 = 1'b0;
      n_push = '0;
      n_pop = '0;
      @(negedge clk);
      note_accepted();
      // A lane that is not ready keeps its request
      hold1 = wb_valid[1] && !wb_ready[1];
      v1 = hold1;
      key1 = {wb_bank[1], wb_slot[1]};
      if (wb_en && pending.size() > 0 && rand_bits(1) == 32'd1)
      begin
         r = rand_bits(8);
         idx = int'(r % 32'(pending.size()));
         key0 = pending[idx];
         v0 = !(hold1 && key0 == key1);
      end
      if (!hold1 && wb_en && pending.size() > 1 && rand_bits(1) == 32'd1)
      begin
         r = rand_bits(8);
         idx = int'(r % 32'(pending.size()));
         key1 = pending[idx];
         v1 = !(v0 && key1 == key0);
      end
      // Pushes and pops every other cycle keep the sampled state safe to act on
      if (push_en && push_size == '0 && push_ready)
      begin
         r = rand_bits(2);
         n_push = (p_banks_def+1)'(r % 32'(BANKS + 1));
      end
      if (pop_en && cmt_pop_size == '0)
      begin
         lanes_valid = 0;
         for (int i = 0; i < BANKS; i++)
            if (cmt_valid[i])
               lanes_valid++;
         r = rand_bits(2);
         n_pop = (p_banks_def+1)'(r % 32'(lanes_valid + 1));
      end
      @(posedge clk);
      push_size <= n_push;
      for (int i = 0; i < BANKS; i++)
      begin
         r = rand_bits(32);
         pay.pc = r;
         r = rand_bits(reg_aw);
         pay.rd = r[reg_aw-1:0];
         push_payload[i] <= pay;
      end
      cmt_pop_size <= n_pop;
      r = rand_bits(32);
      res.result = r;
      r = rand_bits(1);
      res.exc = r[0];
      wb_valid[0] <= v0;
      wb_bank[0] <= key0[KW-1:p_depth_def];
      wb_slot[0] <= key0[p_depth_def-1:0];
      wb_result[0] <= res;
      wb_valid[1] <= v1;
      if (!hold1)
      begin
         r = rand_bits(32);
         res.result = r;
         wb_bank[1] <= key1[KW-1:p_depth_def];
         wb_slot[1] <= key1[p_depth_def-1:0];
         wb_result[1] <= res;
      end
   endtask

   task automatic drain();
      while (in_flight > 0)
         step(1'b0, 1'b1, 1'b1);
   endtask

   task automatic apply_flush();
      @(negedge clk);
      note_accepted();
      @(posedge clk);
      flush <= 1'b1;
      push_size <= '0;
      cmt_pop_size <= '0;
      wb_valid[0] <= 1'b0;
      wb_valid[1] <= 1'b0;
      @(negedge clk);
      note_accepted();
      @(posedge clk);
      flush <= 1'b0;
   endtask

   initial
   begin
      lfsr = 32'h5e89_4290;
      in_flight = 0;
      rst_n <= 1'b0;
      flush <= 1'b0;
      push_size <= '0;
      cmt_pop_size <= '0;
      for (int i = 0; i < BANKS; i++)
         push_payload[i] <= '0;
      for (int l = 0; l < wb_lanes; l++)
      begin
         wb_valid[l] <= 1'b0;
         wb_bank[l] <= '0;
         wb_slot[l] <= '0;
         wb_result[l] <= '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      for (int c = 0; c < RANDOM_LEN; c++)
         step(1'b1, 1'b1, 1'b1);
      drain();
      i_checker.report_test("random traffic");

      // No pops, so the banks fill up
      for (int c = 0; c < FULL_LEN; c++)
         step(1'b1, 1'b1, 1'b0);
      drain();
      i_checker.report_test("full back-pressure");

      for (int c = 0; c < FLUSH_LEN; c++)
         step(1'b1, 1'b1, 1'b1);
      apply_flush();
      for (int c = 0; c < FLUSH_LEN; c++)
         step(1'b1, 1'b1, 1'b1);
      drain();
      i_checker.report_test("flush");

      i_checker.report_total();
      if (i_checker.errors == 0 && i_dut.i_props.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: list.f
source/rob_cfg_pkg.sv
source/rob_types_pkg.sv
source/rob_entry_store.sv
source/rob_bank.sv
source/rob_ring_ptr.sv
source/rob_wb_route.sv
source/rob_commit_sel.sv
source/rob_top.sv
dv/rob_props.sv
dv/rob_checker.sv
dv/tb_rob_top.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench

VERILATOR   ?= verilator
TOP         ?= tb_rob_top
OBJ_DIR     ?= obj_dir
SIM         ?= $(OBJ_DIR)/V$(TOP)
VFLAGS      ?= --binary --assert -j 0
ERROR_LIMIT ?= 100
FILE_LIST   ?= list.f

SRCS := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
